// ==== include/grid_rx_macros.svh ====
// Grid router receive link constants
// Lane count, symbol and character widths, comma pattern, lock thresholds

`ifndef GRID_RX_MACROS_SVH
`define GRID_RX_MACROS_SVH

// Number of serial lanes bonded into one word
`define GRID_RX_LANES 3

// Group-coded symbol on the wire
// Marker "01" plus three 4-bit code groups
`define GRID_RX_SYM_W 14

// Decoded character, 3 bits per code group
`define GRID_RX_CHAR_W 9

// Alignment comma, seven ones then seven zeros
// Data symbols never hold a run of seven equal bits
`define GRID_RX_COMMA 14'b11_1111_1000_0000

// Consecutive aligned commas before a lane counts as locked
`define GRID_RX_LOCK_COUNT 4

// Consecutive code errors that throw a locked lane back to hunt
`define GRID_RX_ERR_LIMIT 2

`endif

// ==== verilog/grid_rx_pkg.sv ====
// Grid router receive types
// Symbol, character, bonded word and lane lock state

`include "grid_rx_macros.svh"

package grid_rx_pkg;

    // ======================================================================
    // Payload types
    // ======================================================================

    // Raw 14-bit symbol as cut from the serial stream
    typedef logic [`GRID_RX_SYM_W-1:0] gcr_sym_t;

    // Decoded 9-bit character
    typedef logic [`GRID_RX_CHAR_W-1:0] gcr_char_t;

    // Bonded word for the UART side
    // Lane 2 in the top bits, lane 0 in the bottom bits
    typedef logic [`GRID_RX_LANES*`GRID_RX_CHAR_W-1:0] rx_word_t;

    // ======================================================================
    // Control types
    // ======================================================================

    // Per-lane word alignment state
    //   st_hunt    searching for a comma, slipping one bit per miss
    //   st_verify  comma seen, counting consecutive aligned commas
    //   st_locked  boundary trusted, data characters accepted
    typedef enum logic [1:0] {
        st_hunt,
        st_verify,
        st_locked
    } lane_state_t;

endpackage

// ==== verilog/grid_rx_lane_if.sv ====
// Grid router lane bundle
// Carries one lane from deserialiser to decoder to control block

`timescale 1ns/1ps

interface grid_rx_lane_if;

    import grid_rx_pkg::*;

    // Deserialiser to decoder
    logic      sym_valid;
    gcr_sym_t  sym;

    // Decoder to control, one result per chr_valid
    logic      chr_valid;
    gcr_char_t chr;
    logic      is_comma;
    logic      code_err;

    // Control back to deserialiser, shifts the boundary one bit
    logic      slip;

    modport deser (
        output sym_valid,
        output sym,
        input  slip
    );

    modport decoder (
        input  sym_valid,
        input  sym,
        output chr_valid,
        output chr,
        output is_comma,
        output code_err
    );

    modport control (
        input  chr_valid,
        input  chr,
        input  is_comma,
        input  code_err,
        output slip
    );

endinterface

// ==== verilog/grid_rx_deser.sv ====
// Grid router lane deserialiser
// Cuts one bit per cycle into 14-bit symbols, slip stretches a symbol by one bit

`timescale 1ns/1ps

`include "grid_rx_macros.svh"

module grid_rx_deser (
    input logic           pclk,
    input logic           arst_n,
    input logic           seri,
    grid_rx_lane_if.deser lane
);

    import grid_rx_pkg::*;

    localparam int CNT_W = $clog2(`GRID_RX_SYM_W);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`GRID_RX_SYM_W - 1);

    // Bit position inside the current symbol
    logic [CNT_W-1:0] bit_cnt;

    // Incoming bits, newest at bit 0
    gcr_sym_t shift_q;

    // Last bit of a symbol sampled at the coming edge
    logic sym_done;

    // ======================================================================
    // Shift path
    // ======================================================================

    // MSB arrives first, so it ends up at the top after 14 shifts
    always_ff @(posedge pclk) begin
        shift_q <= {shift_q[`GRID_RX_SYM_W-2:0], seri};
    end

    // Symbol stays put in shift_q for the sym_valid cycle
    assign lane.sym = shift_q;

    // ======================================================================
    // Bit counter
    // ======================================================================

    // A slip holds the count for one cycle
    // The symbol then spans 15 bits and its oldest bit falls off the top
    assign sym_done = (bit_cnt == CNT_LAST) && !lane.slip;

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt        <= '0;
            lane.sym_valid <= 1'b0;
        end else begin
            // Strobe lands in the cycle after the 14th bit is sampled
            lane.sym_valid <= sym_done;
            if (!lane.slip) begin
                if (bit_cnt == CNT_LAST) begin
                    bit_cnt <= '0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // Control answers two cycles after sym_valid, well clear of the next one
    a_slip_not_on_sym : assert property (
        @(posedge pclk) disable iff (!arst_n)
        !(lane.slip && lane.sym_valid)
    );

endmodule

// ==== verilog/grid_rx_gcr_decoder.sv ====
// Grid router group-code decoder
// Maps a 14-bit symbol to a 9-bit character, flags commas and code errors

`timescale 1ns/1ps

`include "grid_rx_macros.svh"

module grid_rx_gcr_decoder (
    input logic             pclk,
    input logic             arst_n,
    grid_rx_lane_if.decoder lane
);

    import grid_rx_pkg::*;

    // Three 4-bit groups, each worth 3 character bits
    localparam int GRP_N = `GRID_RX_CHAR_W / 3;

    logic      sym_comma;
    logic      marker_ok;
    logic      groups_ok;
    logic [3:0] grp_res;
    gcr_char_t dec_chr;

    // ======================================================================
    // Code table
    // ======================================================================

    // Result is {valid, value}
    // The eight groups not listed are illegal
    function automatic logic [3:0] gcr_group(input logic [3:0] grp);
        case (grp)
            4'b1010: return 4'b1_000;
            4'b1011: return 4'b1_001;
            4'b1101: return 4'b1_010;
            4'b1110: return 4'b1_011;
            4'b0101: return 4'b1_100;
            4'b0110: return 4'b1_101;
            4'b0111: return 4'b1_110;
            4'b1001: return 4'b1_111;
            default: return 4'b0_000;
        endcase
    endfunction

    // ======================================================================
    // Symbol checks
    // ======================================================================

    always_comb begin
        sym_comma = (lane.sym == `GRID_RX_COMMA);
        // Data symbols start with "01"
        marker_ok = (lane.sym[`GRID_RX_SYM_W-1 -: 2] == 2'b01);
        groups_ok = marker_ok;
        grp_res   = '0;
        dec_chr   = '0;
        // Group 0 sits at the bottom and carries the low character bits
        for (int i = 0; i < GRP_N; i++) begin
            grp_res            = gcr_group(lane.sym[4*i +: 4]);
            groups_ok          = groups_ok && grp_res[3];
            dec_chr[3*i +: 3]  = grp_res[2:0];
        end
    end

    // ======================================================================
    // Output register
    // ======================================================================

    // One result per symbol, exactly one of data, comma or error
    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            lane.chr_valid <= 1'b0;
            lane.is_comma  <= 1'b0;
            lane.code_err  <= 1'b0;
        end else begin
            lane.chr_valid <= lane.sym_valid;
            lane.is_comma  <= lane.sym_valid && sym_comma;
            lane.code_err  <= lane.sym_valid && !sym_comma && !groups_ok;
        end
    end

    // Character payload, only meaningful when neither flag is set
    always_ff @(posedge pclk) begin
        if (lane.sym_valid) begin
            lane.chr <= dec_chr;
        end
    end

    // An unknown symbol would slip through as data with no flag raised
    a_sym_known : assert property (
        @(posedge pclk) disable iff (!arst_n)
        lane.sym_valid |-> !$isunknown(lane.sym)
    );

endmodule

// ==== verilog/grid_rx_control.sv ====
// Grid router receive control
// Per-lane lock FSMs with slip requests, and the three-lane word gather

`timescale 1ns/1ps

`include "grid_rx_macros.svh"

module grid_rx_control (
    input  logic                         pclk,
    input  logic                         arst_n,
    grid_rx_lane_if.control              lanes [`GRID_RX_LANES],
    output grid_rx_pkg::rx_word_t        word,
    output logic                         word_valid,
    output logic [`GRID_RX_LANES-1:0]    lock
);

    import grid_rx_pkg::*;

    // One run counter per lane serves both comma and error counting
    localparam int RUN_W = $clog2(`GRID_RX_LOCK_COUNT + `GRID_RX_ERR_LIMIT);
    localparam logic [RUN_W-1:0] LOCK_LAST = RUN_W'(`GRID_RX_LOCK_COUNT - 1);
    localparam logic [RUN_W-1:0] ERR_LAST  = RUN_W'(`GRID_RX_ERR_LIMIT - 1);

    // Lane is locked and has a character for the next word
    logic [`GRID_RX_LANES-1:0] ready;
    // All lanes ready, word goes out at the next edge
    logic                      emit;
    // Word as it would look with this cycle's characters folded in
    rx_word_t                  word_next;

    for (genvar g = 0; g < `GRID_RX_LANES; g++) begin : g_lane

        lane_state_t      state;
        logic [RUN_W-1:0] run;
        logic             fresh;
        gcr_char_t        held;
        logic             data_in;

        assign data_in = lanes[g].chr_valid && !lanes[g].is_comma && !lanes[g].code_err;
        assign lock[g] = (state == st_locked);

        // Newest character wins, whether held or arriving now
        assign ready[g] = lock[g] && (fresh || data_in);
        assign word_next[g*`GRID_RX_CHAR_W +: `GRID_RX_CHAR_W] =
            data_in ? lanes[g].chr : held;

        // ==================================================================
        // Lock FSM
        // ==================================================================
        always_ff @(posedge pclk or negedge arst_n) begin
            if (!arst_n) begin
                state         <= st_hunt;
                run           <= '0;
                lanes[g].slip <= 1'b0;
            end else begin
                lanes[g].slip <= 1'b0;
                if (lanes[g].chr_valid) begin
                    case (state)
                        st_hunt: begin
                            // Wrong boundary, move it by one bit and look again
                            if (lanes[g].is_comma) begin
                                state <= st_verify;
                                run   <= RUN_W'(1);
                            end else begin
                                lanes[g].slip <= 1'b1;
                            end
                        end
                        st_verify: begin
                            if (!lanes[g].is_comma) begin
                                state <= st_hunt;
                                run   <= '0;
                            end else if (run == LOCK_LAST) begin
                                state <= st_locked;
                                run   <= '0;
                            end else begin
                                run <= run + 1'b1;
                            end
                        end
                        st_locked: begin
                            // Only back-to-back errors count, anything else resets
                            if (!lanes[g].code_err) begin
                                run <= '0;
                            end else if (run == ERR_LAST) begin
                                state <= st_hunt;
                                run   <= '0;
                            end else begin
                                run <= run + 1'b1;
                            end
                        end
                        default: begin
                            state <= st_hunt;
                            run   <= '0;
                        end
                    endcase
                end
            end
        end

        // ==================================================================
        // Character holding
        // ==================================================================

        // Emit takes precedence, a character arriving with it is consumed
        always_ff @(posedge pclk or negedge arst_n) begin
            if (!arst_n) begin
                fresh <= 1'b0;
            end else if (!lock[g] || emit) begin
                fresh <= 1'b0;
            end else if (data_in) begin
                fresh <= 1'b1;
            end
        end

        always_ff @(posedge pclk) begin
            if (data_in && lock[g]) begin
                held <= lanes[g].chr;
            end
        end

    end

    // ======================================================================
    // Word output
    // ======================================================================

    assign emit = &ready;

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= emit;
        end
    end

    always_ff @(posedge pclk) begin
        if (emit) begin
            word <= word_next;
        end
    end

    // A lane brings at most one character per symbol time
    // so a word is never followed directly by another
    a_word_single : assert property (
        @(posedge pclk) disable iff (!arst_n)
        word_valid |=> !word_valid
    );

endmodule

// ==== verilog/grid_rx_top.sv ====
// Grid router receive top level
// Three independent lanes feeding one control block and a 27-bit word

`timescale 1ns/1ps

`include "grid_rx_macros.svh"

module grid_rx_top (
    input  logic                      pclk,
    input  logic                      arst_n,
    // One sampled bit per lane per cycle, lanes not aligned to each other
    input  logic [`GRID_RX_LANES-1:0] seri,
    output grid_rx_pkg::rx_word_t     word,
    output logic                      word_valid,
    output logic [`GRID_RX_LANES-1:0] lock
);

    // ======================================================================
    // Lane bundles
    // ======================================================================

    // One bundle per lane, deserialiser -> decoder -> control
    grid_rx_lane_if lane_if [`GRID_RX_LANES] ();

    // ======================================================================
    // Per-lane receive path
    // ======================================================================

    for (genvar g = 0; g < `GRID_RX_LANES; g++) begin : g_lane

        // Bit stream to 14-bit symbols, boundary moved by control slips
        grid_rx_deser u_deser (
            .pclk   (pclk),
            .arst_n (arst_n),
            .seri   (seri[g]),
            .lane   (lane_if[g])
        );

        // Symbol to character, comma or code error
        grid_rx_gcr_decoder u_decoder (
            .pclk   (pclk),
            .arst_n (arst_n),
            .lane   (lane_if[g])
        );

    end

    // ======================================================================
    // Lock tracking and word gather
    // ======================================================================

    // Total latency from last data bit to word_valid is 3 cycles
    //   deser 1, decoder 1, gather 1
    grid_rx_control u_control (
        .pclk       (pclk),
        .arst_n     (arst_n),
        .lanes      (lane_if),
        .word       (word),
        .word_valid (word_valid),
        .lock       (lock)
    );

endmodule

// ==== tb/grid_rx_tb.sv ====
// Grid router receive testbench
// Directed tests of lane lock, word gather and error recovery over three lanes

`timescale 1ns/1ps

`include "grid_rx_macros.svh"

module grid_rx_tb;

    import grid_rx_pkg::*;

    localparam int LANES = `GRID_RX_LANES;
    // Marker right, every code group illegal
    localparam gcr_sym_t BAD_SYM = 14'b01_0000_0000_0000;

    logic             pclk;
    logic             arst_n;
    logic [LANES-1:0] seri;
    rx_word_t         word;
    logic             word_valid;
    logic [LANES-1:0] lock;

    // Bits still to send per lane, symbol MSB first
    logic        lane_q [LANES][$];
    // Words in arrival order
    rx_word_t    exp_q [$];
    // Empty lane gets a whole comma, otherwise a single zero
    logic        comma_fill;
    logic [31:0] lfsr_state;

    grid_rx_top u_grid_rx_top (.*);

    initial begin
        pclk = 1'b0;
        forever #20 pclk = ~pclk;
    end

    // ======================================================================
    // Stimulus models
    // ======================================================================

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic rand_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic gcr_char_t rand_char();
        gcr_char_t c = '0;
        for (int i = 0; i < `GRID_RX_CHAR_W; i++) begin
            c = {c[`GRID_RX_CHAR_W-2:0], rand_bit()};
        end
        return c;
    endfunction

    // Encoder side of the group code
    function automatic logic [3:0] code_group(input logic [2:0] v);
        case (v)
            3'd0:    return 4'b1010;
            3'd1:    return 4'b1011;
            3'd2:    return 4'b1101;
            3'd3:    return 4'b1110;
            3'd4:    return 4'b0101;
            3'd5:    return 4'b0110;
            3'd6:    return 4'b0111;
            default: return 4'b1001;
        endcase
    endfunction

    // Most significant group goes first on the wire
    function automatic gcr_sym_t encode_char(input gcr_char_t c);
        return {2'b01, code_group(c[8:6]), code_group(c[5:3]), code_group(c[2:0])};
    endfunction

    task automatic push_symbol(input int l, input gcr_sym_t s);
        for (int i = `GRID_RX_SYM_W - 1; i >= 0; i--) begin
            lane_q[l].push_back(s[i]);
        end
    endtask

    // ======================================================================
    // Checks
    // ======================================================================

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input rx_word_t got, input rx_word_t exp);
        if (got !== exp) begin
            $display("[FAIL] word got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_lock(input logic [LANES-1:0] got, input logic [LANES-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] lock got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    // One bit per lane per cycle, words checked while stable at the falling edge
    task automatic step_cycle();
        @(negedge pclk);
        if (word_valid) begin
            if (exp_q.size() == 0) begin
                $display("word_valid pulsed while no word was expected");
                abort_run();
            end
            check_word(word, exp_q.pop_front());
        end
        for (int l = 0; l < LANES; l++) begin
            if (lane_q[l].size() == 0) begin
                if (comma_fill) begin
                    push_symbol(l, `GRID_RX_COMMA);
                end else begin
                    lane_q[l].push_back(1'b0);
                end
            end
            seri[l] = lane_q[l].pop_front();
        end
    endtask

    task automatic wait_lock(input logic [LANES-1:0] exp, input int limit);
        int n = 0;
        while (lock !== exp) begin
            if (n == limit) begin
                $display("lock did not reach %h in time", exp);
                abort_run();
            end
            step_cycle();
            n++;
        end
    endtask

    task automatic wait_drained(input int limit);
        int n = 0;
        while (exp_q.size() != 0) begin
            if (n == limit) begin
                $display("%0d expected words never arrived", exp_q.size());
                abort_run();
            end
            step_cycle();
            n++;
        end
    endtask

    // Random characters on all lanes, optional extra comma halfway on one lane
    task automatic send_burst(input int n, input int comma_lane);
        gcr_char_t c;
        rx_word_t  w;
        for (int k = 0; k < n; k++) begin
            if (k == n / 2 && comma_lane >= 0) begin
                push_symbol(comma_lane, `GRID_RX_COMMA);
            end
            for (int l = 0; l < LANES; l++) begin
                c = rand_char();
                push_symbol(l, encode_char(c));
                w[l*`GRID_RX_CHAR_W +: `GRID_RX_CHAR_W] = c;
            end
            exp_q.push_back(w);
        end
        wait_drained(14 * n + 200);
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic idle_after_reset();
        check_lock(lock, 3'b000);
        // Zeros decode as code errors, lanes slip forever in hunt
        repeat (80) step_cycle();
        check_lock(lock, 3'b000);
    endtask

    task automatic acquire_lock();
        // Padding of 0, 5 and 11 bits puts each lane on its own phase
        repeat (5) lane_q[1].push_back(1'b0);
        repeat (11) lane_q[2].push_back(1'b0);
        comma_fill = 1'b1;
        wait_lock(3'b111, 2000);
        repeat (100) step_cycle();
        check_lock(lock, 3'b111);
    endtask

    task automatic gather_random_words();
        // Lanes still sit on the phases left by the padding
        send_burst(8, -1);
    endtask

    task automatic skip_inserted_comma();
        int lead = 0;
        // Lane furthest ahead takes the comma, it then trails by under a symbol
        for (int l = 1; l < LANES; l++) begin
            if (lane_q[l].size() < lane_q[lead].size()) begin
                lead = l;
            end
        end
        send_burst(6, lead);
    endtask

    task automatic recover_from_errors();
        int n = 0;
        repeat (`GRID_RX_ERR_LIMIT) push_symbol(1, BAD_SYM);
        while (lock === 3'b111) begin
            if (n == 200) begin
                $display("lane 1 kept lock through consecutive code errors");
                abort_run();
            end
            step_cycle();
            n++;
        end
        check_lock(lock, 3'b101);
        // Fill commas bring lane 1 back, no word meanwhile
        wait_lock(3'b111, 400);
        send_burst(6, -1);
    endtask

    task automatic tolerate_single_error();
        // Other lanes get a comma in the same slot to stay in step
        push_symbol(0, BAD_SYM);
        push_symbol(1, `GRID_RX_COMMA);
        push_symbol(2, `GRID_RX_COMMA);
        send_burst(4, -1);
        check_lock(lock, 3'b111);
    endtask

    initial begin
        arst_n     = 1'b0;
        seri       = '0;
        comma_fill = 1'b0;
        lfsr_state = 32'h7d47_28bc;
        repeat (10) @(negedge pclk);
        arst_n = 1'b1;
        idle_after_reset();
        acquire_lock();
        gather_random_words();
        skip_inserted_comma();
        recover_from_errors();
        tolerate_single_error();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== grid_rx.f ====
+incdir+include
verilog/grid_rx_pkg.sv
verilog/grid_rx_lane_if.sv
verilog/grid_rx_deser.sv
verilog/grid_rx_gcr_decoder.sv
verilog/grid_rx_control.sv
verilog/grid_rx_top.sv
tb/grid_rx_tb.sv
